/* verilog/mult_pkg.sv */
package mult_pkg;

    // *********************************************************************
    // widths.
    // *********************************************************************

    localparam int operand_width = 16;
    localparam int product_width = 32;

    // one partial-product row per bit of operand a.
    localparam int pp_rows = 16;

    // *********************************************************************
    // vector types.
    // *********************************************************************

    typedef logic [operand_width-1:0] operand_t;
    typedef logic [product_width-1:0] product_t;

    // row i is still unshifted here, the tree applies the weight 2**i.
    typedef logic [operand_width-1:0] pp_row_t;
    typedef pp_row_t [pp_rows-1:0]    pp_array_t;

    // *********************************************************************
    // bundles at the top-level ports.
    // *********************************************************************

    typedef struct packed {
        operand_t a;
        operand_t b;
    } mult_operands_t;

    typedef struct packed {
        product_t product;
    } mult_result_t;

endpackage

/* verilog/kogge_stone_adder.sv */
module kogge_stone_adder #(
    parameter int width = 16
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    output logic [width-1:0] sum,
    output logic             carry_out
);

    // group generate per prefix level, level 0 is the bitwise generate.
    logic [width-1:0] gen  [$clog2(width)+1];

    // the last level needs no propagate, only its generate is read.
    logic [width-1:0] prop [$clog2(width)];

    // carry into each bit position.
    logic [width-1:0] carry;

    assign gen[0]  = a & b;
    assign prop[0] = a ^ b;

    // *********************************************************************
    // prefix network, span doubles at every level.
    // *********************************************************************

    for (genvar lvl = 0; lvl < $clog2(width); lvl++) begin : g_level
        for (genvar i = 0; i < width; i++) begin : g_bit
            if (i >= (1 << lvl)) begin : g_merge
                assign gen[lvl+1][i] = gen[lvl][i] |
                                       (prop[lvl][i] & gen[lvl][i-(1<<lvl)]);
            end else begin : g_hold
                // this group already reaches bit 0.
                assign gen[lvl+1][i] = gen[lvl][i];
            end

            if (lvl + 1 < $clog2(width)) begin : g_prop
                if (i >= (1 << lvl)) begin : g_merge
                    assign prop[lvl+1][i] = prop[lvl][i] & prop[lvl][i-(1<<lvl)];
                end else begin : g_hold
                    assign prop[lvl+1][i] = prop[lvl][i];
                end
            end
        end
    end

    // *********************************************************************
    // sum.
    // *********************************************************************

    // no carry in, so bit 0 sees zero and bit i sees the group bits i-1..0.
    assign carry = {gen[$clog2(width)][width-2:0], 1'b0};

    assign sum = prop[0] ^ carry;

    assign carry_out = gen[$clog2(width)][width-1];

endmodule

/* verilog/pp_reduction_tree.sv */
module pp_reduction_tree (
    input  mult_pkg::pp_array_t rows,
    output mult_pkg::product_t  product
);

    // partial sums, each aligned to the weight of its lowest row.
    logic [17:0] level1 [8];
    logic [19:0] level2 [4];
    logic [23:0] level3 [2];

    // *********************************************************************
    // level one: row 2k plus row 2k+1 shifted by one.
    // *********************************************************************

    // bit 0 of the even row has nothing to add to and passes straight on.
    // the carry of the 16-bit add lands in bit 17 of the pair sum.
    for (genvar k = 0; k < 8; k++) begin : g_level1
        logic [15:0] upper;
        logic [15:0] sum;
        logic        carry;

        assign upper = {1'b0, rows[2*k][mult_pkg::operand_width-1:1]};

        kogge_stone_adder #(
            .width(16)
        ) i_adder (
            .a(upper),
            .b(rows[2*k+1]),
            .sum(sum),
            .carry_out(carry)
        );

        assign level1[k] = {carry, sum, rows[2*k][0]};
    end

    // *********************************************************************
    // level two: pairs of level-one sums, shift of two.
    // *********************************************************************

    // four rows of 16 bits fit in 20 bits, so the carry out of the
    // 18-bit span is always zero and is not used.
    for (genvar k = 0; k < 4; k++) begin : g_level2
        logic [17:0] upper;
        logic [17:0] sum;

        assign upper = {2'b00, level1[2*k][17:2]};

        kogge_stone_adder #(
            .width(18)
        ) i_adder (
            .a(upper),
            .b(level1[2*k+1]),
            .sum(sum),
            .carry_out()
        );

        assign level2[k] = {sum, level1[2*k][1:0]};
    end

    // *********************************************************************
    // level three: pairs of level-two sums, shift of four.
    // *********************************************************************

    for (genvar k = 0; k < 2; k++) begin : g_level3
        logic [19:0] upper;
        logic [19:0] sum;

        assign upper = {4'h0, level2[2*k][19:4]};

        kogge_stone_adder #(
            .width(20)
        ) i_adder (
            .a(upper),
            .b(level2[2*k+1]),
            .sum(sum),
            .carry_out()
        );

        assign level3[k] = {sum, level2[2*k][3:0]};
    end

    // *********************************************************************
    // final adder: shift of eight, covers product bits 31 down to 8.
    // *********************************************************************

    logic [23:0] final_upper;
    logic [23:0] final_sum;

    assign final_upper = {8'h00, level3[0][23:8]};

    // ffff * ffff sets bit 31 through the top sum bit, the carry stays zero.
    kogge_stone_adder #(
        .width(24)
    ) i_final_adder (
        .a(final_upper),
        .b(level3[1]),
        .sum(final_sum),
        .carry_out()
    );

    assign product = {final_sum, level3[0][7:0]};

endmodule

/* verilog/multiplier_16bits.sv */
module multiplier_16bits (
    input  mult_pkg::operand_t a,
    input  mult_pkg::operand_t b,
    output mult_pkg::product_t product
);

    mult_pkg::pp_array_t rows;

    // *********************************************************************
    // partial products.
    // *********************************************************************

    // row i is b gated by bit i of a, the weight is applied in the tree.
    for (genvar i = 0; i < mult_pkg::pp_rows; i++) begin : g_row
        assign rows[i] = a[i] ? b : '0;
    end

    // *********************************************************************
    // reduction.
    // *********************************************************************

    pp_reduction_tree i_tree (
        .rows(rows),
        .product(product)
    );

endmodule

/* verilog/mult_pipeline_top.sv */
module mult_pipeline_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  mult_pkg::mult_operands_t operands,
    output logic                     out_valid,
    output mult_pkg::mult_result_t   result
);

    mult_pkg::mult_operands_t operands_q;
    logic                     stage_valid;
    mult_pkg::product_t       product;

    // *********************************************************************
    // valid pipeline.
    // *********************************************************************

    // one bit per stage, so two pairs may be in flight at once.
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
            out_valid   <= 1'b0;
        end else begin
            stage_valid <= in_valid;
            out_valid   <= stage_valid;
        end
    end

    // *********************************************************************
    // data path.
    // *********************************************************************

    always_ff @(posedge clk) begin
        if (in_valid) begin
            operands_q <= operands;
        end
    end

    multiplier_16bits i_multiplier (
        .a(operands_q.a),
        .b(operands_q.b),
        .product(product)
    );

    // result holds its last value between strobes.
    always_ff @(posedge clk) begin
        if (stage_valid) begin
            result.product <= product;
        end
    end

    // *********************************************************************
    // checks.
    // *********************************************************************

    // nothing left in flight comes out after a reset.
    a_reset_clears_out: assert property (
        @(posedge clk) reset |=> !out_valid
    );

    // each strobe reappears two cycles later, and no strobe appears alone.
    a_valid_latency: assert property (
        @(posedge clk) disable iff (reset)
        1'b1 |-> ##2 (out_valid == $past(in_valid, 2))
    );

    // unknown operands would leak through the tree into the product.
    a_result_known: assert property (
        @(posedge clk) disable iff (reset)
        out_valid |-> !$isunknown(result)
    );

endmodule

/* tb/mult_ref_model.svh */
`ifndef MULT_REF_MODEL_SVH
`define MULT_REF_MODEL_SVH

// *********************************************************************
// reference model.
// *********************************************************************

// plain unsigned product, both operands widened to 32 bits first.
function automatic mult_pkg::product_t ref_multiply(
    input mult_pkg::operand_t a,
    input mult_pkg::operand_t b
);
    mult_pkg::product_t wide_a;
    mult_pkg::product_t wide_b;

    wide_a = a;
    wide_b = b;
    return wide_a * wide_b;
endfunction

// *********************************************************************
// result check.
// *********************************************************************

// compares one expected product with the value seen at the output.
// an unknown bit in the actual value never matches.
function automatic bit product_matches(
    input string              test_name,
    input mult_pkg::product_t expected,
    input mult_pkg::product_t actual
);
    if (actual !== expected) begin
        $display("error %s: expected %h, actual %h", test_name, expected, actual);
        return 1'b0;
    end
    return 1'b1;
endfunction

`endif

/* tb/tb_mult_pipeline.sv */
module tb_mult_pipeline;

    `include "mult_ref_model.svh"

    logic                     clk;
    logic                     reset;
    logic                     in_valid;
    mult_pkg::mult_operands_t operands;
    logic                     out_valid;
    mult_pkg::mult_result_t   result;

    // expected products and the cycle in which each input was accepted.
    mult_pkg::product_t expected_q[$];
    int                 issue_q[$];

    int    cycle_count = 0;
    int    pass_count = 0;
    int    fail_count = 0;
    int    results_seen = 0;
    int    fails_at_start = 0;
    string current_test = "reset";

    mult_pipeline_top i_mult_pipeline_top (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .operands(operands),
        .out_valid(out_valid),
        .result(result)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // *********************************************************************
    // monitor and compare, sampled on the falling edge.
    // *********************************************************************

    always @(negedge clk) begin : compare
        mult_pkg::product_t expected;
        int                 issued;

        cycle_count++;
        if (out_valid === 1'b1) begin
            results_seen++;
            if (expected_q.size() == 0) begin
                $display("%s: out_valid rose with no input waiting for a result",
                         current_test);
                fail_count++;
            end else begin
                expected = expected_q.pop_front();
                issued   = issue_q.pop_front();
                if (product_matches(current_test, expected, result.product)) begin
                    pass_count++;
                end else begin
                    fail_count++;
                end
                if (cycle_count - issued != 2) begin
                    $display("error %s: expected latency 2, actual %0d",
                             current_test, cycle_count - issued);
                    fail_count++;
                end
            end
        end

        // a reset at the next edge drops whatever is still in the pipeline.
        if (reset === 1'b1) begin
            expected_q.delete();
            issue_q.delete();
        end else if (in_valid === 1'b1) begin
            expected_q.push_back(ref_multiply(operands.a, operands.b));
            issue_q.push_back(cycle_count);
        end
    end

    // *********************************************************************
    // stimulus helpers.
    // *********************************************************************

    task automatic send_pair(input mult_pkg::operand_t a, input mult_pkg::operand_t b);
        @(posedge clk);
        #1;
        in_valid   = 1'b1;
        operands.a = a;
        operands.b = b;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end
    endtask

    task automatic apply_reset(input int count);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        reset    = 1'b1;
        repeat (count) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic wait_for_drain();
        int cycles;

        cycles = 0;
        while (expected_q.size() != 0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (expected_q.size() != 0) begin
            $display("%s: timed out after 20 cycles with %0d results still missing",
                     current_test, expected_q.size());
            fail_count++;
            expected_q.delete();
            issue_q.delete();
        end
    endtask

    task automatic start_test(input string name);
        current_test   = name;
        results_seen   = 0;
        fails_at_start = fail_count;
    endtask

    task automatic finish_test(input int expected_results);
        if (results_seen != expected_results) begin
            $display("error %s: expected %0d results, actual %0d",
                     current_test, expected_results, results_seen);
            fail_count++;
        end
        $display("%s: %0d results, %0d failed checks",
                 current_test, results_seen, fail_count - fails_at_start);
    endtask

    // *********************************************************************
    // test sequence.
    // *********************************************************************

    initial begin
        void'($urandom(32'hf92ef5d9));
        reset    = 1'b1;
        in_valid = 1'b0;
        operands = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("corner_values");
        send_pair(16'h0000, 16'h0000);
        send_pair(16'h0001, 16'h0001);
        send_pair(16'hffff, 16'hffff);
        send_pair(16'h8000, 16'h8000);
        send_pair(16'hffff, 16'h0001);
        send_pair(16'h0000, 16'hffff);
        idle_cycles(1);
        wait_for_drain();
        finish_test(6);

        // one set bit selects exactly one partial-product row.
        start_test("walking_ones");
        for (int i = 0; i < 16; i++) begin
            send_pair(16'h0001 << i, 16'hffff);
        end
        for (int i = 0; i < 16; i++) begin
            send_pair(16'hffff, 16'h0001 << i);
        end
        idle_cycles(1);
        wait_for_drain();
        finish_test(32);

        start_test("random_stream");
        for (int i = 0; i < 200; i++) begin
            send_pair(16'($urandom()), 16'($urandom()));
        end
        idle_cycles(1);
        wait_for_drain();
        finish_test(200);

        start_test("latency_and_gaps");
        for (int i = 0; i < 40; i++) begin
            send_pair(16'($urandom()), 16'($urandom()));
            idle_cycles($urandom_range(4, 0));
        end
        idle_cycles(1);
        wait_for_drain();
        finish_test(40);

        // the first pair leaves during the reset cycle, the second is dropped.
        start_test("reset_flush");
        send_pair(16'($urandom()), 16'($urandom()));
        send_pair(16'($urandom()), 16'($urandom()));
        apply_reset(1);
        @(negedge clk);
        if (out_valid !== 1'b0) begin
            $display("error %s: expected out_valid 0, actual %b", current_test, out_valid);
            fail_count++;
        end else begin
            pass_count++;
        end
        idle_cycles(3);
        send_pair(16'($urandom()), 16'($urandom()));
        idle_cycles(1);
        wait_for_drain();
        finish_test(2);

        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+tb
verilog/mult_pkg.sv
verilog/kogge_stone_adder.sv
verilog/pp_reduction_tree.sv
verilog/multiplier_16bits.sv
verilog/mult_pipeline_top.sv
tb/tb_mult_pipeline.sv
